// File: dv/tb_happy_emoji.sv
`timescale 1ns/10ps

module tb_happy_emoji
  import emoji_pkg::*;
();

  localparam int HOLD_REST   = 40;
  localparam int HOLD_OPEN   = 20;
  localparam int HOLD_GRIN   = 20;
  localparam int HOLD_LAUGH  = 40;
  localparam int LOOP_CYCLES = HOLD_REST + HOLD_OPEN + HOLD_GRIN + HOLD_LAUGH;
  localparam int WAIT_LIMIT  = 200;

  // One position in flight, with the frame it was presented in
  typedef struct packed
  {
    logic       valid;
    frame_e     frame;
    pixel_pos_t pos;
  } probe_t;

  logic        clk;
  logic        i_rst_n;
  pixel_pos_t  i_pos;
  color_t      o_color;
  frame_e      o_frame;
  logic        pos_valid;
  logic [31:0] lfsr_state;
  probe_t      pipe [2];
  frame_e      model_frame;
  int          cycles_left;
  logic        model_on;
  int          sweep_rows[$];
  int          sweep_cols[$];

  happy_emoji_top #(
    .REST_CYCLES  (frame_cycles_t'(HOLD_REST)),
    .OPEN_CYCLES  (frame_cycles_t'(HOLD_OPEN)),
    .GRIN_CYCLES  (frame_cycles_t'(HOLD_GRIN)),
    .LAUGH_CYCLES (frame_cycles_t'(HOLD_LAUGH))
  ) dut (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_pos   (i_pos),
    .o_color (o_color),
    .o_frame (o_frame)
  );

  initial
  begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  task automatic check_value(input logic [31:0] got, input logic [31:0] exp, input string what);
    if (got !== exp)
    begin
      $display("[FAIL] %0t: %s, got %0h, expected %0h", $time, what, got, exp);
      $display("SIMULATION FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  ////////////////////
  // Random source

  function automatic logic [31:0] lfsr_next(logic [31:0] s);
    logic [31:0] n;
    n = s >> 1;
    if (s[0])
      n = n ^ 32'hD000_0001;
    return n;
  endfunction

  // One LFSR step per bit taken
  task automatic draw_bits(input int count, output int value);
    value = 0;
    for (int i = 0; i < count; i++)
    begin
      value = (value << 1) | int'(lfsr_state[0]);
      lfsr_state = lfsr_next(lfsr_state);
    end
  endtask

  ////////////////////
  // Expected picture

  function automatic logic in_span(int x, int lo, int hi);
    return (x >= lo) && (x <= hi);
  endfunction

  function automatic color_t expected_color(pixel_pos_t p, frame_e f);
    int        h;
    int        v;
    row_kind_t kind;
    color_t    result;
    h = int'(p.h);
    v = int'(p.v);
    kind = ROW_BACKGROUND;
    if (in_span(v, 135, 204))
      kind = ROW_SKIN;
    else if (in_span(v, 205, 216))
      kind = ROW_EYES;
    else if (in_span(v, 217, 413))
    begin
      kind = ROW_SKIN;
      case (f)
        FRAME_REST:
          if (in_span(v, 305, 309))
            kind = ROW_MOUTH;
        FRAME_OPEN:
          if (in_span(v, 305, 325))
            kind = ROW_MOUTH;
        FRAME_GRIN:
        begin
          if (in_span(v, 290, 296) || in_span(v, 325, 331))
            kind = ROW_MOUTH;
          if (in_span(v, 297, 324))
            kind = ROW_TEETH;
        end
        default:
        begin
          if (in_span(v, 283, 289) || in_span(v, 310, 313) || in_span(v, 344, 350))
            kind = ROW_MOUTH;
          if (in_span(v, 290, 309) || in_span(v, 314, 343))
            kind = ROW_TEETH_SPLIT;
        end
      endcase
    end
    result = COLOR_YELLOW;
    if (kind == ROW_BACKGROUND || !in_span(h, 324, 603))
      result = COLOR_WHITE;
    else if (kind == ROW_EYES && (in_span(h, 371, 382) || in_span(h, 545, 556)))
      result = COLOR_BLACK;
    else if (kind == ROW_MOUTH && in_span(h, 371, 556))
      result = COLOR_BLACK;
    else if ((kind == ROW_TEETH || kind == ROW_TEETH_SPLIT) && in_span(h, 371, 556))
    begin
      result = COLOR_WHITE;
      if (!in_span(h, 378, 549))
        result = COLOR_BLACK;
      if (kind == ROW_TEETH_SPLIT &&
          (in_span(h, 418, 421) || in_span(h, 462, 465) || in_span(h, 506, 509)))
        result = COLOR_BLACK;
    end
    return result;
  endfunction

  ////////////////////
  // Frame sequence model

  function automatic int hold_cycles_of(frame_e f);
    int n;
    case (f)
      FRAME_REST: n = HOLD_REST;
      FRAME_OPEN: n = HOLD_OPEN;
      FRAME_GRIN: n = HOLD_GRIN;
      default:    n = HOLD_LAUGH;
    endcase
    return n;
  endfunction

  function automatic frame_e following_frame(frame_e f);
    frame_e n;
    case (f)
      FRAME_REST: n = FRAME_OPEN;
      FRAME_OPEN: n = FRAME_GRIN;
      FRAME_GRIN: n = FRAME_LAUGH;
      default:    n = FRAME_REST;
    endcase
    return n;
  endfunction

  // After the update, model_frame is what o_frame shows after the next rising edge
  always @(negedge clk)
  begin
    if (model_on)
    begin
      check_value(32'(o_frame), 32'(model_frame), "o_frame against frame sequence");
      if (cycles_left == 1)
      begin
        model_frame = following_frame(model_frame);
        cycles_left = hold_cycles_of(model_frame);
      end
      else
        cycles_left = cycles_left - 1;
    end
  end

  // Color comes out two edges after the position is sampled
  always @(negedge clk)
  begin
    if (pipe[1].valid)
      check_value(32'(o_color), 32'(expected_color(pipe[1].pos, pipe[1].frame)),
                  $sformatf("o_color at h=%0d v=%0d in %s",
                            pipe[1].pos.h, pipe[1].pos.v, pipe[1].frame.name()));
    pipe[1] = pipe[0];
    pipe[0] = '{valid: pos_valid, frame: o_frame, pos: i_pos};
  end

  ////////////////////
  // Directed sweep

  task automatic load_sweep_rows(input frame_e f);
    case (f)
      FRAME_REST: sweep_rows = '{134, 135, 204, 205, 216, 217, 304, 305, 309, 310, 413, 414};
      FRAME_OPEN: sweep_rows = '{134, 135, 204, 205, 216, 217, 304, 305, 325, 326, 413, 414};
      FRAME_GRIN: sweep_rows = '{134, 135, 204, 205, 216, 217, 289, 290, 296, 297,
                                 324, 325, 331, 332, 413, 414};
      default:    sweep_rows = '{134, 135, 204, 205, 216, 217, 282, 283, 289, 290,
                                 309, 310, 313, 314, 343, 344, 350, 351, 413, 414};
    endcase
  endtask

  // Background filler until the position can be painted in frame f
  task automatic drive_in_frame(input frame_e f, input pixel_pos_t p);
    int waited;
    waited = 0;
    @(posedge clk);
    while (model_frame != f)
    begin
      i_pos <= '{h: 10'd0, v: 10'd0};
      pos_valid <= 1'b1;
      waited = waited + 1;
      if (waited > WAIT_LIMIT)
      begin
        $display("Timed out waiting for frame %s to come around", f.name());
        $display("SIMULATION FAILED");
        $fatal(1, "wait timeout");
      end
      @(posedge clk);
    end
    i_pos <= p;
    pos_valid <= 1'b1;
  endtask

  initial
  begin : stimulus
    int h_val;
    int v_val;
    i_rst_n = 1'b0;
    i_pos = '0;
    pos_valid = 1'b0;
    lfsr_state = 32'd85304;
    model_on = 1'b0;
    model_frame = FRAME_REST;
    cycles_left = 0;
    pipe[0] = '0;
    pipe[1] = '0;
    sweep_cols = '{323, 324, 370, 371, 377, 378, 382, 383, 417, 418, 421, 422, 461, 462,
                   465, 466, 505, 506, 509, 510, 544, 545, 549, 550, 556, 557, 603, 604};

    repeat (2) @(posedge clk);
    @(negedge clk);
    check_value(32'(o_frame), 32'(FRAME_REST), "o_frame in reset");
    check_value(32'(o_color), 32'(COLOR_WHITE), "o_color in reset");
    @(posedge clk);
    i_rst_n <= 1'b1;
    cycles_left = HOLD_REST;
    model_on = 1'b1;

    // Random pixels over two animation loops
    repeat (2 * LOOP_CYCLES)
    begin
      @(posedge clk);
      draw_bits(10, h_val);
      draw_bits(9, v_val);
      i_pos <= '{h: pixel_coord_t'(h_val % 640), v: pixel_coord_t'(v_val % 480)};
      pos_valid <= 1'b1;
    end

    for (int fi = 0; fi < 4; fi++)
    begin
      load_sweep_rows(frame_e'(fi));
      foreach (sweep_rows[r])
        foreach (sweep_cols[c])
          drive_in_frame(frame_e'(fi), '{h: pixel_coord_t'(sweep_cols[c]),
                                         v: pixel_coord_t'(sweep_rows[r])});
    end

    // This pixel differs between every pair of neighbouring frames
    repeat (LOOP_CYCLES + 10)
    begin
      @(posedge clk);
      i_pos <= '{h: 10'd419, v: 10'd320};
      pos_valid <= 1'b1;
    end

    @(posedge clk);
    pos_valid <= 1'b0;
    repeat (3) @(posedge clk);
    $display("SIMULATION PASSED");
    $finish;
  end

endmodule

// File: files.f
src/emoji_pkg.sv
src/frame_timer.sv
src/frame_fsm.sv
src/face_row_decoder.sv
src/pixel_painter.sv
src/happy_emoji_top.sv
dv/tb_happy_emoji.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, then scan the log

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal -f files.f --top-module tb_happy_emoji \
  -Mdir "$BUILD_DIR" -o sim_happy_emoji
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"$BUILD_DIR/sim_happy_emoji" > "$LOG_FILE" 2>&1
sim_status=$?
cat "$LOG_FILE"
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status"
  exit 1
fi

if grep -q "SIMULATION FAILED" "$LOG_FILE"; then
  echo "Failure found in $LOG_FILE"
  exit 1
fi

echo "No failure found in $LOG_FILE"
exit 0

// File: src/emoji_pkg.sv
package emoji_pkg;

  ////////////////////
  // Basic types

  // One screen coordinate, up to 1023
  typedef logic [9:0]  pixel_coord_t;

  // RGB444, red in the top nibble
  typedef logic [11:0] color_t;

  // Hold count per frame, enough for 37.5M cycles
  typedef logic [25:0] frame_cycles_t;

  typedef enum logic [1:0]
  {
    FRAME_REST,
    FRAME_OPEN,
    FRAME_GRIN,
    FRAME_LAUGH
  } frame_e;

  // Row classes passed from the decoder to the painter
  typedef logic [2:0] row_kind_t;

  localparam row_kind_t ROW_BACKGROUND  = 3'd0;
  localparam row_kind_t ROW_SKIN        = 3'd1;
  localparam row_kind_t ROW_EYES        = 3'd2;
  localparam row_kind_t ROW_MOUTH       = 3'd3;
  localparam row_kind_t ROW_TEETH       = 3'd4;
  localparam row_kind_t ROW_TEETH_SPLIT = 3'd5;

  typedef struct packed
  {
    pixel_coord_t h;
    pixel_coord_t v;
  } pixel_pos_t;

  typedef struct packed
  {
    row_kind_t    kind;
    pixel_coord_t h;
  } row_tag_t;

  ////////////////////
  // Colors

  localparam color_t COLOR_WHITE  = 12'hFFF;
  localparam color_t COLOR_YELLOW = 12'hFF0;
  localparam color_t COLOR_BLACK  = 12'h000;

  ////////////////////
  // Face geometry
  // Columns are left inclusive, right exclusive

  localparam pixel_coord_t FACE_LEFT   = 10'd324;
  localparam pixel_coord_t FACE_RIGHT  = 10'd604;
  localparam pixel_coord_t FACE_TOP    = 10'd135;
  localparam pixel_coord_t FACE_BOTTOM = 10'd414;

  localparam pixel_coord_t EYE_TOP         = 10'd205;
  localparam pixel_coord_t EYE_BOTTOM      = 10'd217;
  localparam pixel_coord_t LEFT_EYE_LEFT   = 10'd371;
  localparam pixel_coord_t LEFT_EYE_RIGHT  = 10'd383;
  localparam pixel_coord_t RIGHT_EYE_LEFT  = 10'd545;
  localparam pixel_coord_t RIGHT_EYE_RIGHT = 10'd557;

  localparam pixel_coord_t MOUTH_LEFT  = 10'd371;
  localparam pixel_coord_t MOUTH_RIGHT = 10'd557;

  // Teeth sit inside the mouth, leaving black corners
  localparam pixel_coord_t TEETH_LEFT    = 10'd378;
  localparam pixel_coord_t TEETH_RIGHT   = 10'd550;
  localparam pixel_coord_t TOOTH_WIDTH   = 10'd40;
  localparam pixel_coord_t DIVIDER_WIDTH = 10'd4;

endpackage

// File: src/face_row_decoder.sv
`timescale 1ns/10ps

module face_row_decoder
  import emoji_pkg::*;
(
  input  logic       clk,
  input  logic       i_rst_n,
  input  pixel_pos_t i_pos,
  input  frame_e     i_frame,
  output row_tag_t   o_tag
);

  ////////////////////
  // Mouth bands per frame
  // Each value is the first row of the next band

  // Rest, thin bar
  localparam pixel_coord_t REST_MOUTH_TOP = 10'd305;
  localparam pixel_coord_t REST_CHIN_TOP  = 10'd310;

  // Open, taller bar
  localparam pixel_coord_t OPEN_MOUTH_TOP = 10'd305;
  localparam pixel_coord_t OPEN_CHIN_TOP  = 10'd326;

  // Grin, lips around one teeth block
  localparam pixel_coord_t GRIN_LIP_TOP       = 10'd290;
  localparam pixel_coord_t GRIN_TEETH_TOP     = 10'd297;
  localparam pixel_coord_t GRIN_LOWER_LIP_TOP = 10'd325;
  localparam pixel_coord_t GRIN_CHIN_TOP      = 10'd332;

  // Laugh, two rows of teeth with a gap
  localparam pixel_coord_t LAUGH_LIP_TOP         = 10'd283;
  localparam pixel_coord_t LAUGH_UPPER_TEETH_TOP = 10'd290;
  localparam pixel_coord_t LAUGH_GAP_TOP         = 10'd310;
  localparam pixel_coord_t LAUGH_LOWER_TEETH_TOP = 10'd314;
  localparam pixel_coord_t LAUGH_LOWER_LIP_TOP   = 10'd344;
  localparam pixel_coord_t LAUGH_CHIN_TOP        = 10'd351;

  row_kind_t kind_d;
  row_kind_t kind_q;
  pixel_coord_t h_q;

  always_comb
  begin
    kind_d = ROW_SKIN;
    if (i_pos.v < FACE_TOP || i_pos.v >= FACE_BOTTOM)
      kind_d = ROW_BACKGROUND;
    else if (i_pos.v < EYE_TOP)
      kind_d = ROW_SKIN;
    else if (i_pos.v < EYE_BOTTOM)
      kind_d = ROW_EYES;
    else
    begin
      // Below the eyes only the mouth changes between frames
      case (i_frame)
        FRAME_REST:
        begin
          if (i_pos.v >= REST_MOUTH_TOP && i_pos.v < REST_CHIN_TOP)
            kind_d = ROW_MOUTH;
        end
        FRAME_OPEN:
        begin
          if (i_pos.v >= OPEN_MOUTH_TOP && i_pos.v < OPEN_CHIN_TOP)
            kind_d = ROW_MOUTH;
        end
        FRAME_GRIN:
        begin
          if (i_pos.v < GRIN_LIP_TOP)
            kind_d = ROW_SKIN;
          else if (i_pos.v < GRIN_TEETH_TOP)
            kind_d = ROW_MOUTH;
          else if (i_pos.v < GRIN_LOWER_LIP_TOP)
            kind_d = ROW_TEETH;
          else if (i_pos.v < GRIN_CHIN_TOP)
            kind_d = ROW_MOUTH;
        end
        default:
        begin
          if (i_pos.v < LAUGH_LIP_TOP)
            kind_d = ROW_SKIN;
          else if (i_pos.v < LAUGH_UPPER_TEETH_TOP)
            kind_d = ROW_MOUTH;
          else if (i_pos.v < LAUGH_GAP_TOP)
            kind_d = ROW_TEETH_SPLIT;
          else if (i_pos.v < LAUGH_LOWER_TEETH_TOP)
            kind_d = ROW_MOUTH;
          else if (i_pos.v < LAUGH_LOWER_LIP_TOP)
            kind_d = ROW_TEETH_SPLIT;
          else if (i_pos.v < LAUGH_CHIN_TOP)
            kind_d = ROW_MOUTH;
        end
      endcase
    end
  end

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      kind_q <= ROW_BACKGROUND;
    else
      kind_q <= kind_d;
  end

  // Column rides along with the row class
  always_ff @(posedge clk)
  begin
    h_q <= i_pos.h;
  end

  assign o_tag = '{kind: kind_q, h: h_q};

endmodule

// File: src/frame_fsm.sv
`timescale 1ns/10ps

module frame_fsm
  import emoji_pkg::*;
(
  input  logic   clk,
  input  logic   i_rst_n,
  input  logic   i_frame_done,
  output frame_e o_frame
);

  frame_e frame_next;

  ////////////////////
  // Next frame in the loop

  always_comb
  begin
    case (o_frame)
      FRAME_REST:  frame_next = FRAME_OPEN;
      FRAME_OPEN:  frame_next = FRAME_GRIN;
      FRAME_GRIN:  frame_next = FRAME_LAUGH;
      default:     frame_next = FRAME_REST;
    endcase
  end

  ////////////////////
  // State register

  // Steps only on the timer pulse
  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      o_frame <= FRAME_REST;
    else if (i_frame_done)
      o_frame <= frame_next;
  end

endmodule

// File: src/frame_timer.sv
`timescale 1ns/10ps

module frame_timer
  import emoji_pkg::*;
#(
  parameter frame_cycles_t REST_CYCLES  = frame_cycles_t'(37_500_000),
  parameter frame_cycles_t OPEN_CYCLES  = frame_cycles_t'(2_500_000),
  parameter frame_cycles_t GRIN_CYCLES  = frame_cycles_t'(2_500_000),
  parameter frame_cycles_t LAUGH_CYCLES = frame_cycles_t'(37_500_000)
)
(
  input  logic   clk,
  input  logic   i_rst_n,
  input  frame_e i_frame,
  output logic   o_frame_done
);

  frame_cycles_t hold_cycles;
  frame_cycles_t count_q;

  // Hold time of the frame now on screen
  always_comb
  begin
    case (i_frame)
      FRAME_REST: hold_cycles = REST_CYCLES;
      FRAME_OPEN: hold_cycles = OPEN_CYCLES;
      FRAME_GRIN: hold_cycles = GRIN_CYCLES;
      default:    hold_cycles = LAUGH_CYCLES;
    endcase
  end

  // Last cycle of the hold
  assign o_frame_done = (count_q == hold_cycles - frame_cycles_t'(1));

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      count_q <= '0;
    else if (o_frame_done)
      count_q <= '0;
    else
      count_q <= count_q + frame_cycles_t'(1);
  end

endmodule

// File: src/happy_emoji_top.sv
`timescale 1ns/10ps

module happy_emoji_top
  import emoji_pkg::*;
#(
  // Hold times in clock cycles, defaults for a 25 MHz pixel clock
  parameter frame_cycles_t REST_CYCLES  = frame_cycles_t'(37_500_000),
  parameter frame_cycles_t OPEN_CYCLES  = frame_cycles_t'(2_500_000),
  parameter frame_cycles_t GRIN_CYCLES  = frame_cycles_t'(2_500_000),
  parameter frame_cycles_t LAUGH_CYCLES = frame_cycles_t'(37_500_000)
)
(
  input  logic       clk,
  input  logic       i_rst_n,
  input  pixel_pos_t i_pos,
  output color_t     o_color,
  output frame_e     o_frame
);

  logic     frame_done;
  row_tag_t row_tag;

  ////////////////////
  // Animation control

  frame_timer #(
    .REST_CYCLES  (REST_CYCLES),
    .OPEN_CYCLES  (OPEN_CYCLES),
    .GRIN_CYCLES  (GRIN_CYCLES),
    .LAUGH_CYCLES (LAUGH_CYCLES)
  ) u_frame_timer (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_frame      (o_frame),
    .o_frame_done (frame_done)
  );

  frame_fsm u_frame_fsm (
    .clk          (clk),
    .i_rst_n      (i_rst_n),
    .i_frame_done (frame_done),
    .o_frame      (o_frame)
  );

  ////////////////////
  // Pixel pipeline
  // Row classify, then paint, two cycles in total

  face_row_decoder u_face_row_decoder (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_pos   (i_pos),
    .i_frame (o_frame),
    .o_tag   (row_tag)
  );

  pixel_painter u_pixel_painter (
    .clk     (clk),
    .i_rst_n (i_rst_n),
    .i_tag   (row_tag),
    .o_color (o_color)
  );

endmodule

// File: src/pixel_painter.sv
`timescale 1ns/10ps

module pixel_painter
  import emoji_pkg::*;
(
  input  logic     clk,
  input  logic     i_rst_n,
  input  row_tag_t i_tag,
  output color_t   o_color
);

  // Four teeth, so three dividers between them
  localparam int NUM_TEETH = 4;

  logic   in_face;
  logic   in_eye;
  logic   in_mouth;
  logic   in_teeth;
  logic   on_divider;
  color_t color_d;

  // True on the black gap between two teeth
  function automatic logic is_divider(pixel_coord_t h);
    int   lo;
    logic hit;
    hit = 1'b0;
    for (int k = 1; k < NUM_TEETH; k++)
    begin
      lo = TEETH_LEFT + k * TOOTH_WIDTH + (k - 1) * DIVIDER_WIDTH;
      if (h >= lo && h < lo + DIVIDER_WIDTH)
        hit = 1'b1;
    end
    return hit;
  endfunction

  ////////////////////
  // Column ranges

  assign in_face    = (i_tag.h >= FACE_LEFT) && (i_tag.h < FACE_RIGHT);
  assign in_eye     = ((i_tag.h >= LEFT_EYE_LEFT) && (i_tag.h < LEFT_EYE_RIGHT)) ||
                      ((i_tag.h >= RIGHT_EYE_LEFT) && (i_tag.h < RIGHT_EYE_RIGHT));
  assign in_mouth   = (i_tag.h >= MOUTH_LEFT) && (i_tag.h < MOUTH_RIGHT);
  assign in_teeth   = (i_tag.h >= TEETH_LEFT) && (i_tag.h < TEETH_RIGHT);
  assign on_divider = is_divider(i_tag.h);

  ////////////////////
  // Color select

  always_comb
  begin
    color_d = COLOR_YELLOW;
    if (!in_face || i_tag.kind == ROW_BACKGROUND)
      color_d = COLOR_WHITE;
    else
    begin
      case (i_tag.kind)
        ROW_EYES:
          if (in_eye)
            color_d = COLOR_BLACK;
        ROW_MOUTH:
          if (in_mouth)
            color_d = COLOR_BLACK;
        ROW_TEETH, ROW_TEETH_SPLIT:
        begin
          // Mouth corners and dividers stay black
          if (in_mouth)
            color_d = COLOR_BLACK;
          if (in_teeth && !(i_tag.kind == ROW_TEETH_SPLIT && on_divider))
            color_d = COLOR_WHITE;
        end
        default:
          color_d = COLOR_YELLOW;
      endcase
    end
  end

  always_ff @(posedge clk or negedge i_rst_n)
  begin
    if (!i_rst_n)
      o_color <= COLOR_WHITE;
    else
      o_color <= color_d;
  end

endmodule
